// ==== design/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    parameter int csr_addr_w = 14;
    parameter int csr_data_w = 32;

    // register map
    parameter logic [csr_addr_w-1:0] addr_crmd   = 14'h0;
    parameter logic [csr_addr_w-1:0] addr_prmd   = 14'h1;
    parameter logic [csr_addr_w-1:0] addr_ecfg   = 14'h4;
    parameter logic [csr_addr_w-1:0] addr_estat  = 14'h5;
    parameter logic [csr_addr_w-1:0] addr_era    = 14'h6;
    parameter logic [csr_addr_w-1:0] addr_eentry = 14'hc;
    parameter logic [csr_addr_w-1:0] addr_save0  = 14'h30;
    parameter logic [csr_addr_w-1:0] addr_save1  = 14'h31;
    parameter logic [csr_addr_w-1:0] addr_save2  = 14'h32;
    parameter logic [csr_addr_w-1:0] addr_save3  = 14'h33;
    parameter logic [csr_addr_w-1:0] addr_tcfg   = 14'h41;
    parameter logic [csr_addr_w-1:0] addr_tval   = 14'h42;
    parameter logic [csr_addr_w-1:0] addr_ticlr  = 14'h44;

    // crmd fields
    parameter int crmd_plv_hi  = 1;
    parameter int crmd_plv_lo  = 0;
    parameter int crmd_ie      = 2;
    parameter int crmd_da      = 3;
    parameter int crmd_pg      = 4;
    parameter int crmd_datf_hi = 6;
    parameter int crmd_datf_lo = 5;
    parameter int crmd_datm_hi = 8;
    parameter int crmd_datm_lo = 7;

    // prmd fields
    parameter int prmd_pplv_hi = 1;
    parameter int prmd_pplv_lo = 0;
    parameter int prmd_pie     = 2;

    // estat fields
    parameter int estat_sw_hi       = 1;
    parameter int estat_sw_lo       = 0;
    parameter int estat_hw_hi       = 9;
    parameter int estat_hw_lo       = 2;
    parameter int estat_ti          = 11;
    parameter int estat_ecode_hi    = 21;
    parameter int estat_ecode_lo    = 16;
    parameter int estat_esubcode_hi = 30;
    parameter int estat_esubcode_lo = 22;

    // ecfg mask and estat status share bits 12:0
    parameter int int_w = 13;

    parameter int tcfg_en         = 0;
    parameter int tcfg_periodic   = 1;
    parameter int tcfg_initval_lo = 2;

    parameter int ticlr_clr = 0;

    parameter int eentry_va_lo = 6;

    // direct address mode out of reset
    parameter logic [csr_data_w-1:0] crmd_reset = 32'h0000_0008;

endpackage

`default_nettype wire

// ==== design/csr_trap_state.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_trap_state (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            csr_wr_en,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  wire  [csr_pkg::csr_data_w-1:0] csr_wdata,
    input  wire                            excp_flush,
    input  wire                            ertn_flush,
    input  wire  [csr_pkg::csr_data_w-1:0] era_in,
    output logic [csr_pkg::csr_data_w-1:0] crmd,
    output logic [csr_pkg::csr_data_w-1:0] prmd,
    output logic [csr_pkg::csr_data_w-1:0] era,
    output logic [csr_pkg::csr_data_w-1:0] eentry,
    output logic                           crmd_ie,
    output logic [1:0]                     plv_out,
    output logic [1:0]                     dapg,
    output logic [1:0]                     datf,
    output logic [1:0]                     datm,
    output logic [csr_pkg::csr_data_w-1:0] eentry_out,
    output logic [csr_pkg::csr_data_w-1:0] era_out
);
    import csr_pkg::*;

    wire crmd_wen   = csr_wr_en && (csr_waddr == addr_crmd);
    wire prmd_wen   = csr_wr_en && (csr_waddr == addr_prmd);
    wire era_wen    = csr_wr_en && (csr_waddr == addr_era);
    wire eentry_wen = csr_wr_en && (csr_waddr == addr_eentry);

    logic [csr_data_w-1:eentry_va_lo] eentry_va;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= crmd_reset;
        end else if (excp_flush) begin
            crmd[crmd_plv_hi:crmd_plv_lo] <= 2'b00;
            crmd[csr_pkg::crmd_ie] <= 1'b0;
        end else if (ertn_flush) begin
            crmd[crmd_plv_hi:crmd_plv_lo] <= prmd[prmd_pplv_hi:prmd_pplv_lo];
            crmd[csr_pkg::crmd_ie] <= prmd[prmd_pie];
        end else if (crmd_wen) begin
            crmd[crmd_plv_hi:crmd_plv_lo]   <= csr_wdata[crmd_plv_hi:crmd_plv_lo];
            crmd[csr_pkg::crmd_ie]          <= csr_wdata[csr_pkg::crmd_ie];
            crmd[crmd_da]                   <= csr_wdata[crmd_da];
            crmd[crmd_pg]                   <= csr_wdata[crmd_pg];
            crmd[crmd_datf_hi:crmd_datf_lo] <= csr_wdata[crmd_datf_hi:crmd_datf_lo];
            crmd[crmd_datm_hi:crmd_datm_lo] <= csr_wdata[crmd_datm_hi:crmd_datm_lo];
        end
    end

    // previous mode saved on entry
    always_ff @(posedge clk) begin
        if (reset) begin
            prmd <= '0;
        end else if (excp_flush) begin
            prmd[prmd_pplv_hi:prmd_pplv_lo] <= crmd[crmd_plv_hi:crmd_plv_lo];
            prmd[prmd_pie] <= crmd[csr_pkg::crmd_ie];
        end else if (prmd_wen) begin
            prmd[prmd_pplv_hi:prmd_pplv_lo] <= csr_wdata[prmd_pplv_hi:prmd_pplv_lo];
            prmd[prmd_pie] <= csr_wdata[prmd_pie];
        end
    end

    always_ff @(posedge clk) begin
        if (excp_flush) begin
            era <= era_in;
        end else if (era_wen) begin
            era <= csr_wdata;
        end
        if (eentry_wen) begin
            eentry_va <= csr_wdata[csr_data_w-1:eentry_va_lo];
        end
    end

    assign eentry = {eentry_va, {eentry_va_lo{1'b0}}};

    // level that takes effect at the next edge
    always_comb begin
        if (excp_flush) begin
            plv_out = 2'b00;
        end else if (ertn_flush) begin
            plv_out = prmd[prmd_pplv_hi:prmd_pplv_lo];
        end else if (crmd_wen) begin
            plv_out = csr_wdata[crmd_plv_hi:crmd_plv_lo];
        end else begin
            plv_out = crmd[crmd_plv_hi:crmd_plv_lo];
        end
    end

    assign crmd_ie    = crmd[csr_pkg::crmd_ie];
    assign dapg       = {crmd[crmd_da], crmd[crmd_pg]};
    assign datf       = crmd[crmd_datf_hi:crmd_datf_lo];
    assign datm       = crmd[crmd_datm_hi:crmd_datm_lo];
    assign eentry_out = eentry;
    assign era_out    = era;

endmodule

`default_nettype wire

// ==== design/csr_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_timer #(
    parameter int TIMER_BITS = 32
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            csr_wr_en,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  wire  [csr_pkg::csr_data_w-1:0] csr_wdata,
    output logic [csr_pkg::csr_data_w-1:0] tcfg,
    output logic [csr_pkg::csr_data_w-1:0] tval,
    output logic                           timer_pending
);
    import csr_pkg::*;

    wire tcfg_wen  = csr_wr_en && (csr_waddr == addr_tcfg);
    wire ticlr_wen = csr_wr_en && (csr_waddr == addr_ticlr);

    logic                                timer_en;
    logic                                periodic;
    logic [csr_data_w-1:tcfg_initval_lo] tcfg_initval;
    logic [TIMER_BITS-1:0]               count;

    wire expire = timer_en && (count == '0);

    // initval scaled by four
    wire [TIMER_BITS-1:0] load_new = TIMER_BITS'({csr_wdata[csr_data_w-1:tcfg_initval_lo],
                                                  {tcfg_initval_lo{1'b0}}});
    wire [TIMER_BITS-1:0] load_cur = TIMER_BITS'({tcfg_initval, {tcfg_initval_lo{1'b0}}});

    always_ff @(posedge clk) begin
        if (reset) begin
            timer_en <= 1'b0;
            periodic <= 1'b0;
            count    <= '0;
        end else if (tcfg_wen) begin
            timer_en <= csr_wdata[tcfg_en];
            periodic <= csr_wdata[tcfg_periodic];
            count    <= load_new;
        end else if (expire) begin
            // one-shot stops and parks at all ones
            timer_en <= periodic;
            count    <= periodic ? load_cur : '1;
        end else if (timer_en) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tcfg_wen) begin
            tcfg_initval <= csr_wdata[csr_data_w-1:tcfg_initval_lo];
        end
    end

    // clear wins over a new expiry
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_pending <= 1'b0;
        end else if (ticlr_wen && csr_wdata[ticlr_clr]) begin
            timer_pending <= 1'b0;
        end else if (expire) begin
            timer_pending <= 1'b1;
        end
    end

    always_comb begin
        tcfg = '0;
        tcfg[tcfg_en] = timer_en;
        tcfg[tcfg_periodic] = periodic;
        tcfg[csr_data_w-1:tcfg_initval_lo] = tcfg_initval;
    end

    assign tval = csr_data_w'(count);

endmodule

`default_nettype wire

// ==== design/csr_int_status.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_int_status (
    input  wire                            clk,
    input  wire                            reset,
    input  wire                            csr_wr_en,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  wire  [csr_pkg::csr_data_w-1:0] csr_wdata,
    input  wire                            excp_flush,
    input  wire  [5:0]                     ecode_in,
    input  wire  [8:0]                     esubcode_in,
    input  wire  [7:0]                     interrupt,
    input  wire                            timer_pending,
    input  wire                            crmd_ie,
    output logic [csr_pkg::csr_data_w-1:0] ecfg,
    output logic [csr_pkg::csr_data_w-1:0] estat,
    output logic                           has_int
);
    import csr_pkg::*;

    wire ecfg_wen  = csr_wr_en && (csr_waddr == addr_ecfg);
    wire estat_wen = csr_wr_en && (csr_waddr == addr_estat);

    logic [int_w-1:0] ecfg_lie;
    logic [1:0]       is_sw;
    logic [7:0]       is_hw;
    logic [5:0]       ecode;
    logic [8:0]       esubcode;

    always_ff @(posedge clk) begin
        if (reset) begin
            ecfg_lie <= '0;
            is_sw    <= '0;
            is_hw    <= '0;
        end else begin
            if (ecfg_wen) begin
                ecfg_lie <= csr_wdata[int_w-1:0];
            end
            if (estat_wen) begin
                is_sw <= csr_wdata[estat_sw_hi:estat_sw_lo];
            end
            // hardware lines one cycle late
            is_hw <= interrupt;
        end
    end

    // code fields written by hardware only
    always_ff @(posedge clk) begin
        if (excp_flush) begin
            ecode    <= ecode_in;
            esubcode <= esubcode_in;
        end
    end

    assign ecfg = csr_data_w'(ecfg_lie);

    always_comb begin
        estat = '0;
        estat[estat_sw_hi:estat_sw_lo] = is_sw;
        estat[estat_hw_hi:estat_hw_lo] = is_hw;
        estat[estat_ti] = timer_pending;
        estat[estat_ecode_hi:estat_ecode_lo] = ecode;
        estat[estat_esubcode_hi:estat_esubcode_lo] = esubcode;
    end

    assign has_int = crmd_ie && ((ecfg_lie & estat[int_w-1:0]) != '0);

endmodule

`default_nettype wire

// ==== design/csr_read_port.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_read_port (
    input  wire                            clk,
    input  wire                            csr_wr_en,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  wire  [csr_pkg::csr_data_w-1:0] csr_wdata,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_raddr,
    input  wire  [csr_pkg::csr_data_w-1:0] crmd,
    input  wire  [csr_pkg::csr_data_w-1:0] prmd,
    input  wire  [csr_pkg::csr_data_w-1:0] ecfg,
    input  wire  [csr_pkg::csr_data_w-1:0] estat,
    input  wire  [csr_pkg::csr_data_w-1:0] era,
    input  wire  [csr_pkg::csr_data_w-1:0] eentry,
    input  wire  [csr_pkg::csr_data_w-1:0] tcfg,
    input  wire  [csr_pkg::csr_data_w-1:0] tval,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] save0;
    logic [csr_data_w-1:0] save1;
    logic [csr_data_w-1:0] save2;
    logic [csr_data_w-1:0] save3;

    // scratch registers
    always_ff @(posedge clk) begin
        if (csr_wr_en) begin
            case (csr_waddr)
                addr_save0: save0 <= csr_wdata;
                addr_save1: save1 <= csr_wdata;
                addr_save2: save2 <= csr_wdata;
                addr_save3: save3 <= csr_wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        if (csr_wr_en && (csr_waddr == csr_raddr)) begin
            // write in flight
            csr_rdata = csr_wdata;
        end else begin
            case (csr_raddr)
                addr_crmd:   csr_rdata = crmd;
                addr_prmd:   csr_rdata = prmd;
                addr_ecfg:   csr_rdata = ecfg;
                addr_estat:  csr_rdata = estat;
                addr_era:    csr_rdata = era;
                addr_eentry: csr_rdata = eentry;
                addr_save0:  csr_rdata = save0;
                addr_save1:  csr_rdata = save1;
                addr_save2:  csr_rdata = save2;
                addr_save3:  csr_rdata = save3;
                addr_tcfg:   csr_rdata = tcfg;
                addr_tval:   csr_rdata = tval;
                default:     csr_rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_top #(
    parameter int TIMER_BITS = 32
) (
    input  wire                            clk,
    input  wire                            reset,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_raddr,
    input  wire                            csr_wr_en,
    input  wire  [csr_pkg::csr_addr_w-1:0] csr_waddr,
    input  wire  [csr_pkg::csr_data_w-1:0] csr_wdata,
    input  wire                            excp_flush,
    input  wire                            ertn_flush,
    input  wire  [csr_pkg::csr_data_w-1:0] era_in,
    input  wire  [5:0]                     ecode_in,
    input  wire  [8:0]                     esubcode_in,
    input  wire  [7:0]                     interrupt,
    output logic [csr_pkg::csr_data_w-1:0] csr_rdata,
    output logic [csr_pkg::csr_data_w-1:0] eentry_out,
    output logic [csr_pkg::csr_data_w-1:0] era_out,
    output logic [1:0]                     plv_out,
    output logic [1:0]                     dapg,
    output logic [1:0]                     datf,
    output logic [1:0]                     datm,
    output logic                           has_int
);
    import csr_pkg::*;

    logic [csr_data_w-1:0] crmd;
    logic [csr_data_w-1:0] prmd;
    logic [csr_data_w-1:0] era;
    logic [csr_data_w-1:0] eentry;
    logic [csr_data_w-1:0] ecfg;
    logic [csr_data_w-1:0] estat;
    logic [csr_data_w-1:0] tcfg;
    logic [csr_data_w-1:0] tval;
    logic                  crmd_ie;
    logic                  timer_pending;

    csr_trap_state csr_trap_state_i (
        .clk, .reset, .csr_wr_en, .csr_waddr, .csr_wdata,
        .excp_flush, .ertn_flush, .era_in,
        .crmd, .prmd, .era, .eentry, .crmd_ie,
        .plv_out, .dapg, .datf, .datm, .eentry_out, .era_out
    );

    csr_timer #(
        .TIMER_BITS(TIMER_BITS)
    ) csr_timer_i (
        .clk, .reset, .csr_wr_en, .csr_waddr, .csr_wdata,
        .tcfg, .tval, .timer_pending
    );

    csr_int_status csr_int_status_i (
        .clk, .reset, .csr_wr_en, .csr_waddr, .csr_wdata,
        .excp_flush, .ecode_in, .esubcode_in, .interrupt,
        .timer_pending, .crmd_ie,
        .ecfg, .estat, .has_int
    );

    csr_read_port csr_read_port_i (
        .clk, .csr_wr_en, .csr_waddr, .csr_wdata, .csr_raddr,
        .crmd, .prmd, .ecfg, .estat, .era, .eentry, .tcfg, .tval,
        .csr_rdata
    );

endmodule

`default_nettype wire

// ==== bench/csr_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_checker (
    input  wire         clk,
    input  wire  [3:0]  chk_op,
    input  wire  [13:0] chk_addr,
    input  wire  [31:0] chk_exp,
    input  wire  [31:0] chk_mask,
    input  wire  [31:0] csr_rdata,
    input  wire  [31:0] eentry_out,
    input  wire  [31:0] era_out,
    input  wire  [1:0]  plv_out,
    input  wire  [1:0]  dapg,
    input  wire  [1:0]  datf,
    input  wire  [1:0]  datm,
    input  wire         has_int,
    output logic [31:0] check_count,
    output logic [31:0] error_count
);
    import csr_pkg::*;

    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;

    assign check_count = checks;
    assign error_count = errors;

    // falling edge sees settled outputs
    always @(negedge clk) begin : compare
        logic [31:0] got;
        got = 32'h0;
        case (chk_op)
            4'h2, 4'h3, 4'h4: got = csr_rdata;
            4'h5, 4'h6:       got = {30'h0, plv_out};
            // status word msb first as datm datf dapg plv has_int
            4'h7, 4'h8:       got = {23'h0, datm, datf, dapg, plv_out, has_int};
            4'h9:             got = (chk_addr == addr_era) ? era_out : eentry_out;
            default:          got = 32'h0;
        endcase
        if (chk_op inside {[4'h2:4'h9]}) begin
            checks++;
            test_checks++;
            if ((got & chk_mask) !== (chk_exp & chk_mask)) begin
                errors++;
                test_errors++;
                $display("[ERROR] %0t op %0h addr %h: got %h, expected %h (mask %h)",
                         $time, chk_op, chk_addr, got & chk_mask, chk_exp & chk_mask,
                         chk_mask);
            end
        end
        if (chk_op == 4'hf) begin
            $display("test %0d %s: %0d checks, %0d errors", chk_addr,
                     (test_errors == 0) ? "passed" : "failed", test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
        end
    end

endmodule

`default_nettype wire

// ==== bench/csr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_tb #(
    parameter int margin_cycles = 50
);
    localparam int max_vectors = 256;

    logic        clk;
    logic        reset;
    logic [13:0] csr_raddr;
    logic        csr_wr_en;
    logic [13:0] csr_waddr;
    logic [31:0] csr_wdata;
    logic        excp_flush;
    logic        ertn_flush;
    logic [31:0] era_in;
    logic [5:0]  ecode_in;
    logic [8:0]  esubcode_in;
    logic [7:0]  interrupt;

    logic [31:0] csr_rdata;
    logic [31:0] eentry_out;
    logic [31:0] era_out;
    logic [1:0]  plv_out;
    logic [1:0]  dapg;
    logic [1:0]  datf;
    logic [1:0]  datm;
    logic        has_int;

    // what the checker judges in the current cycle
    logic [3:0]  chk_op;
    logic [13:0] chk_addr;
    logic [31:0] chk_exp;
    logic [31:0] chk_mask;
    logic [31:0] check_count;
    logic [31:0] error_count;

    // four words per line as op addr data expected
    logic [31:0] golden [0:4*max_vectors-1];
    logic [31:0] save_model [0:3];
    logic [31:0] lcg_state;
    int          num_vectors;
    int          total_cycles;
    int          cycle_limit;
    int          cycle_count = 0;
    bit          found_end;

    csr_top #(
        .TIMER_BITS(32)
    ) csr_top_i (
        .clk, .reset, .csr_raddr, .csr_wr_en, .csr_waddr, .csr_wdata,
        .excp_flush, .ertn_flush, .era_in, .ecode_in, .esubcode_in, .interrupt,
        .csr_rdata, .eentry_out, .era_out, .plv_out, .dapg, .datf, .datm, .has_int
    );

    csr_checker csr_checker_i (
        .clk, .chk_op, .chk_addr, .chk_exp, .chk_mask,
        .csr_rdata, .eentry_out, .era_out, .plv_out, .dapg, .datf, .datm, .has_int,
        .check_count, .error_count
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // vector count and run length up to the end marker
    task automatic scan_golden();
        int i;
        found_end = 1'b0;
        num_vectors = 0;
        total_cycles = 2;
        for (i = 0; i < max_vectors && !found_end; i++) begin
            if (golden[4*i] === 32'he) begin
                found_end = 1'b1;
            end else if (golden[4*i] === 32'h0) begin
                total_cycles += int'(golden[4*i+2]);
                num_vectors++;
            end else begin
                total_cycles += 1;
                num_vectors++;
            end
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        csr_wr_en  <= 1'b0;
        excp_flush <= 1'b0;
        ertn_flush <= 1'b0;
        chk_op     <= 4'h0;
        chk_mask   <= 32'h0;
    endtask

    task automatic apply_vector(input logic [31:0] vop, input logic [31:0] vaddr,
                                input logic [31:0] vdata, input logic [31:0] vexp);
        if (vop == 32'h0) begin
            repeat (int'(vdata)) idle_cycle();
        end else begin
            idle_cycle();
            chk_op   <= vop[3:0];
            chk_addr <= vaddr[13:0];
            case (vop[3:0])
                4'h1: begin
                    csr_wr_en <= 1'b1;
                    csr_waddr <= vaddr[13:0];
                    csr_wdata <= vdata;
                end
                4'h2, 4'h8, 4'h9: begin
                    csr_raddr <= vaddr[13:0];
                    chk_exp   <= vexp;
                    chk_mask  <= vdata;
                end
                4'h3: begin
                    // read in the write cycle sees the bypassed data
                    lcg_state = lcg_next(lcg_state);
                    save_model[vaddr[1:0]] = lcg_state;
                    csr_wr_en <= 1'b1;
                    csr_waddr <= vaddr[13:0];
                    csr_wdata <= lcg_state;
                    csr_raddr <= vaddr[13:0];
                    chk_exp   <= lcg_state;
                    chk_mask  <= 32'hffff_ffff;
                end
                4'h4: begin
                    csr_raddr <= vaddr[13:0];
                    chk_exp   <= save_model[vaddr[1:0]];
                    chk_mask  <= 32'hffff_ffff;
                end
                4'h5: begin
                    excp_flush  <= 1'b1;
                    era_in      <= vdata;
                    ecode_in    <= vexp[5:0];
                    esubcode_in <= vexp[14:6];
                    // kernel level already visible during the strobe
                    chk_exp     <= 32'h0;
                    chk_mask    <= 32'h3;
                end
                4'h6: begin
                    ertn_flush <= 1'b1;
                    chk_exp    <= vexp;
                    chk_mask   <= 32'h3;
                end
                4'h7: begin
                    lcg_state = lcg_next(lcg_state);
                    interrupt <= vdata[7:0] | (lcg_state[31:24] & vdata[15:8]);
                    chk_exp   <= vexp;
                    chk_mask  <= 32'h1;
                end
                default: ;
            endcase
        end
    endtask

    task automatic run_golden();
        int i;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        for (i = 0; i < num_vectors; i++) begin
            apply_vector(golden[4*i], golden[4*i+1], golden[4*i+2], golden[4*i+3]);
        end
        // last check lands on the following falling edge
        idle_cycle();
        idle_cycle();
    endtask

    initial begin
        reset       <= 1'b1;
        csr_raddr   <= 14'h0;
        csr_wr_en   <= 1'b0;
        csr_waddr   <= 14'h0;
        csr_wdata   <= 32'h0;
        excp_flush  <= 1'b0;
        ertn_flush  <= 1'b0;
        era_in      <= 32'h0;
        ecode_in    <= 6'h0;
        esubcode_in <= 9'h0;
        interrupt   <= 8'h0;
        chk_op      <= 4'h0;
        chk_addr    <= 14'h0;
        chk_exp     <= 32'h0;
        chk_mask    <= 32'h0;
        lcg_state = 32'hd9eb;
        $readmemh("bench/csr_golden.txt", golden);
        scan_golden();
        cycle_limit = total_cycles + 2 + margin_cycles;
        if (!found_end) begin
            $display("golden file bench/csr_golden.txt did not load or has no end marker");
            $display("Errors found");
            $finish;
        end else begin
            run_golden();
            $display("%0d checks, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("No errors");
            end else begin
                $display("Errors found");
            end
            $finish;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Errors found");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/csr_golden.txt ====
// columns: op addr data expect, all hex, one operation per line
// op 0 idle (data = cycles), 1 write, 2 read (data = mask), 3 lcg write with bypass read
// op 4 read scratch, 5 exception (data = era, expect = esubcode:ecode), 6 return (expect = plv)
// op 7 interrupt lines (data[7:0] fixed, data[15:8] lcg), 8 status (data = mask), 9 output
// op f end of test (addr = test number), e end of file
2 0000 ffffffff 00000008
8 0000 000001ff 00000010
2 0041 00000003 00000000
2 0005 00001fff 00000000
f 0001 00000000 00000000
3 0030 00000000 00000000
3 0031 00000000 00000000
3 0032 00000000 00000000
3 0033 00000000 00000000
4 0033 00000000 00000000
4 0030 00000000 00000000
4 0031 00000000 00000000
4 0032 00000000 00000000
2 0044 ffffffff 00000000
2 0100 ffffffff 00000000
f 0002 00000000 00000000
1 000c 1c001234 00000000
9 000c ffffffff 1c001200
2 000c ffffffff 1c001200
1 0000 0000000f 00000000
8 0000 00000006 00000006
5 0006 80001000 0000694b
8 0000 00000006 00000000
2 0001 00000007 00000007
2 0000 00000007 00000000
2 0006 ffffffff 80001000
9 0006 ffffffff 80001000
2 0005 7fff0000 694b0000
6 0000 00000000 00000003
2 0000 00000007 00000007
8 0000 00000006 00000006
f 0003 00000000 00000000
7 0000 0000ff00 00000000
0 0000 00000002 00000000
8 0000 00000001 00000000
7 0000 00000000 00000000
1 0004 00000004 00000000
1 0000 00000008 00000000
7 0000 0000fe01 00000000
8 0000 00000001 00000000
1 0000 0000000c 00000000
8 0000 00000001 00000001
7 0000 0000fe00 00000001
8 0000 00000001 00000000
7 0000 00000001 00000000
8 0000 00000001 00000001
7 0000 00000000 00000001
1 0004 00000001 00000000
1 0005 00000001 00000000
8 0000 00000001 00000001
2 0005 00000003 00000001
1 0005 00000000 00000000
8 0000 00000001 00000000
f 0004 00000000 00000000
1 0041 0000000d 00000000
0 0000 0000000c 00000000
2 0005 00000800 00000000
2 0005 00000800 00000800
2 0041 ffffffff 0000000c
2 0042 ffffffff ffffffff
1 0044 00000001 00000000
2 0005 00000800 00000000
0 0000 00000010 00000000
2 0005 00000800 00000000
1 0041 0000000b 00000000
0 0000 00000008 00000000
2 0005 00000800 00000000
2 0005 00000800 00000800
1 0044 00000001 00000000
2 0005 00000800 00000000
0 0000 00000005 00000000
2 0005 00000800 00000000
2 0005 00000800 00000800
1 0041 00000000 00000000
f 0005 00000000 00000000
e 0000 00000000 00000000

// ==== flist.f ====
design/csr_pkg.sv
design/csr_trap_state.sv
design/csr_timer.sv
design/csr_int_status.sv
design/csr_read_port.sv
design/csr_top.sv
bench/csr_checker.sv
bench/csr_tb.sv

// ==== Makefile ====
# Verilator build and run of the CSR testbench
TOP            ?= csr_tb
FLIST          ?= flist.f
LOG            ?= sim.log
TIMEOUT_CYCLES ?= 50
OBJ_DIR        ?= obj_dir
VERILATOR      ?= verilator

VFLAGS = --binary --timing --top-module $(TOP) -Gmargin_cycles=$(TIMEOUT_CYCLES) \
         -Mdir $(OBJ_DIR)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
